//--- src/cache_params.svh
/*
 * cache geometry macros and the first uncached address
 */

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// direct-mapped geometry
`define CACHE_N_SETS        16
`define CACHE_BLOCK_WORDS   2

// address split: tag | index | offset | byte
`define CACHE_INDEX_BITS    4
`define CACHE_OFFSET_BITS   1
`define CACHE_TAG_BITS      25

// everything at or above this goes straight to memory
`define CACHE_NONCACHE_BASE 32'hF000_0000

`endif

//--- src/cache_pkg.sv
/*
 * bus word and byte-enable types, address field types,
 * the address union and the controller state enum
 */

`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    typedef logic [`CACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [1:0] byte_sel;
    } cache_addr_fields_t;

    // raw view for uncached compare and memory address, fields for lookup
    typedef union packed {
        word_t              raw;
        cache_addr_fields_t fields;
    } cache_addr_t;

    typedef enum logic [2:0] {
        LOOKUP,
        WRITEBACK,
        FETCH,
        PASS,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

//--- src/store_if.sv
/*
 * link between the cache controller and the line store
 */

`timescale 1ns/100ps
`default_nettype none

interface store_if;

    // line select
    cache_pkg::index_t    index;
    cache_pkg::offset_t   offset;

    // word write port, byte lanes merged in the store
    logic                 data_wen;
    cache_pkg::word_t     wr_data;
    cache_pkg::byte_en_t  wr_byte_en;

    // line state write port
    logic                 line_wen;
    cache_pkg::tag_t      wr_tag;
    logic                 wr_valid;
    logic                 wr_dirty;
    logic                 inval_all;

    // selected line and addressed word
    cache_pkg::tag_t      line_tag;
    logic                 line_valid;
    logic                 line_dirty;
    cache_pkg::word_t     rd_data;

    modport ctrl (
        output index, offset, data_wen, wr_data, wr_byte_en,
        output line_wen, wr_tag, wr_valid, wr_dirty, inval_all,
        input  line_tag, line_valid, line_dirty, rd_data
    );

    modport store (
        input  index, offset, data_wen, wr_data, wr_byte_en,
        input  line_wen, wr_tag, wr_valid, wr_dirty, inval_all,
        output line_tag, line_valid, line_dirty, rd_data
    );

endinterface

`default_nettype wire

//--- src/cache_decode.sv
/*
 * request address split, tag compare and uncached range check
 */

`timescale 1ns/100ps
`default_nettype none

`include "cache_params.svh"

module cache_decode (
    input  cache_pkg::cache_addr_t addr,
    input  cache_pkg::tag_t        line_tag,
    input  logic                   line_valid,
    output logic                   hit,
    output logic                   pass_through,
    output cache_pkg::tag_t        tag,
    output cache_pkg::index_t      index,
    output cache_pkg::offset_t     offset
);

    logic tag_match;

    // field view for the lookup
    assign tag    = addr.fields.tag;
    assign index  = addr.fields.index;
    assign offset = addr.fields.offset;

    // raw view for the uncached window
    assign pass_through = (addr.raw >= `CACHE_NONCACHE_BASE);

    assign tag_match = (line_tag == addr.fields.tag);

    // uncached addresses never hit, even on a stale tag match
    assign hit = line_valid && tag_match && !pass_through;

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
/*
 * cache control FSM: hit service, victim writeback, block fill,
 * uncached pass-through and full flush sweep
 */

`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   ren,
    input  logic                   wen,
    input  cache_pkg::word_t       wdata,
    input  cache_pkg::byte_en_t    byte_en,
    input  logic                   flush,
    input  logic                   hit,
    input  logic                   pass_through,
    input  cache_pkg::tag_t        tag,
    input  cache_pkg::index_t      index,
    input  cache_pkg::offset_t     offset,
    input  cache_pkg::cache_addr_t addr,
    output logic                   busy,
    output cache_pkg::word_t       rdata,
    output logic                   flush_done,
    output logic                   mem_ren,
    output logic                   mem_wen,
    output cache_pkg::word_t       mem_addr,
    output cache_pkg::word_t       mem_wdata,
    output cache_pkg::byte_en_t    mem_byte_en,
    input  cache_pkg::word_t       mem_rdata,
    input  logic                   mem_busy,
    store_if.ctrl                  st
);

    cache_pkg::cache_state_t state, state_n;
    cache_pkg::offset_t      word_cnt, word_cnt_n;
    cache_pkg::index_t       set_cnt, set_cnt_n;
    logic                    flush_req, flush_req_n;
    logic                    req;

    assign req = ren || wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= cache_pkg::LOOKUP;
            word_cnt  <= '0;
            set_cnt   <= '0;
            flush_req <= 1'b0;
        end else begin
            state     <= state_n;
            word_cnt  <= word_cnt_n;
            set_cnt   <= set_cnt_n;
            flush_req <= flush_req_n;
        end
    end

    always_comb begin
        state_n       = state;
        word_cnt_n    = word_cnt;
        set_cnt_n     = set_cnt;
        flush_req_n   = flush_req || flush;
        busy          = 1'b1;
        rdata         = '0;
        flush_done    = 1'b0;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        mem_addr      = '0;
        mem_wdata     = '0;
        mem_byte_en   = '1;
        st.index      = index;
        st.offset     = word_cnt;
        st.data_wen   = 1'b0;
        st.wr_data    = wdata;
        st.wr_byte_en = byte_en;
        st.line_wen   = 1'b0;
        st.wr_tag     = tag;
        st.wr_valid   = 1'b1;
        st.wr_dirty   = 1'b0;
        st.inval_all  = 1'b0;

        case (state)
            cache_pkg::LOOKUP: begin
                st.offset  = offset;
                word_cnt_n = '0;
                set_cnt_n  = '0;
                if (flush || flush_req) begin
                    // pending flush wins over any request
                    flush_req_n = 1'b0;
                    state_n     = cache_pkg::FLUSH;
                end else if (req && pass_through) begin
                    state_n = cache_pkg::PASS;
                end else if (req && hit) begin
                    busy  = 1'b0;
                    rdata = st.rd_data;
                    if (wen) begin
                        st.data_wen = 1'b1;
                        st.line_wen = 1'b1;
                        st.wr_dirty = 1'b1;
                    end
                end else if (req) begin
                    // miss, victim goes out first if it holds modified data
                    if (st.line_valid && st.line_dirty)
                        state_n = cache_pkg::WRITEBACK;
                    else
                        state_n = cache_pkg::FETCH;
                end
            end
            cache_pkg::WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = {st.line_tag, index, word_cnt, 2'b00};
                mem_wdata = st.rd_data;
                if (!mem_busy) begin
                    word_cnt_n = word_cnt + 1'b1;
                    if (&word_cnt)
                        state_n = cache_pkg::FETCH;
                end
            end
            cache_pkg::FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {tag, index, word_cnt, 2'b00};
                if (!mem_busy) begin
                    st.data_wen    = 1'b1;
                    st.wr_data     = mem_rdata;
                    st.wr_byte_en  = '1;
                    word_cnt_n     = word_cnt + 1'b1;
                    // install tag with the last word, then replay as a hit
                    if (&word_cnt) begin
                        st.line_wen = 1'b1;
                        state_n     = cache_pkg::LOOKUP;
                    end
                end
            end
            cache_pkg::PASS: begin
                mem_ren     = ren;
                mem_wen     = wen;
                mem_addr    = addr.raw;
                mem_wdata   = wdata;
                mem_byte_en = byte_en;
                busy        = mem_busy;
                rdata       = mem_rdata;
                if (!mem_busy)
                    state_n = cache_pkg::LOOKUP;
            end
            cache_pkg::FLUSH: begin
                st.index = set_cnt;
                if (st.line_valid && st.line_dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {st.line_tag, set_cnt, word_cnt, 2'b00};
                    mem_wdata = st.rd_data;
                    if (!mem_busy) begin
                        word_cnt_n = word_cnt + 1'b1;
                        if (&word_cnt)
                            set_cnt_n = set_cnt + 1'b1;
                    end
                end else begin
                    // clean or empty set, nothing to write back
                    word_cnt_n = '0;
                    set_cnt_n  = set_cnt + 1'b1;
                end
                if ((&set_cnt) && (set_cnt_n != set_cnt)) begin
                    st.inval_all = 1'b1;
                    flush_done   = 1'b1;
                    state_n      = cache_pkg::LOOKUP;
                end
            end
            default: begin
                state_n = cache_pkg::LOOKUP;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/cache_store.sv
/*
 * tag, valid, dirty and data arrays with a byte-merge word write
 */

`timescale 1ns/100ps
`default_nettype none

`include "cache_params.svh"

module cache_store (
    input  logic   CLK,
    input  logic   nRST,
    store_if.store st
);

    cache_pkg::tag_t  tag_q  [`CACHE_N_SETS];
    cache_pkg::word_t data_q [`CACHE_N_SETS][`CACHE_BLOCK_WORDS];
    logic [`CACHE_N_SETS-1:0] valid_q;
    logic [`CACHE_N_SETS-1:0] dirty_q;

    // line state, invalidate-all has priority
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (st.inval_all) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (st.line_wen) begin
            valid_q[st.index] <= st.wr_valid;
            dirty_q[st.index] <= st.wr_dirty;
        end
    end

    always_ff @(posedge CLK) begin
        if (st.line_wen)
            tag_q[st.index] <= st.wr_tag;
        if (st.data_wen) begin
            for (int i = 0; i < 4; i++) begin
                if (st.wr_byte_en[i])
                    data_q[st.index][st.offset][8*i +: 8] <= st.wr_data[8*i +: 8];
            end
        end
    end

    assign st.line_tag   = tag_q[st.index];
    assign st.line_valid = valid_q[st.index];
    assign st.line_dirty = dirty_q[st.index];
    assign st.rd_data    = data_q[st.index][st.offset];

endmodule

`default_nettype wire

//--- src/l1_cache.sv
/*
 * direct-mapped write-back L1 data cache top level,
 * decode, control FSM and line store wired together
 */

`timescale 1ns/100ps
`default_nettype none

module l1_cache (
    input  logic                   CLK,
    input  logic                   nRST,

    // processor bus
    input  logic                   ren,
    input  logic                   wen,
    input  cache_pkg::cache_addr_t addr,
    input  cache_pkg::word_t       wdata,
    input  cache_pkg::byte_en_t    byte_en,
    output cache_pkg::word_t       rdata,
    output logic                   busy,

    // memory bus
    output logic                   mem_ren,
    output logic                   mem_wen,
    output cache_pkg::word_t       mem_addr,
    output cache_pkg::word_t       mem_wdata,
    output cache_pkg::byte_en_t    mem_byte_en,
    input  cache_pkg::word_t       mem_rdata,
    input  logic                   mem_busy,

    // flush
    input  logic                   flush,
    output logic                   flush_done
);

    logic               hit;
    logic               pass_through;
    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  req_index;
    cache_pkg::offset_t req_offset;

    store_if st_if ();

    cache_decode i_decode (
        .addr         (addr),
        .line_tag     (st_if.line_tag),
        .line_valid   (st_if.line_valid),
        .hit          (hit),
        .pass_through (pass_through),
        .tag          (req_tag),
        .index        (req_index),
        .offset       (req_offset)
    );

    cache_ctrl i_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .ren          (ren),
        .wen          (wen),
        .wdata        (wdata),
        .byte_en      (byte_en),
        .flush        (flush),
        .hit          (hit),
        .pass_through (pass_through),
        .tag          (req_tag),
        .index        (req_index),
        .offset       (req_offset),
        .addr         (addr),
        .busy         (busy),
        .rdata        (rdata),
        .flush_done   (flush_done),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .st           (st_if.ctrl)
    );

    cache_store i_store (
        .CLK  (CLK),
        .nRST (nRST),
        .st   (st_if.store)
    );

endmodule

`default_nettype wire

//--- tb/mem_model.sv
/*
 * behavioral memory on the cache memory bus: fixed busy delay,
 * sparse word store with byte enables, transfer counters
 */

`timescale 1ns/100ps
`default_nettype none

module mem_model (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                mem_ren,
    input  logic                mem_wen,
    input  cache_pkg::word_t    mem_addr,
    input  cache_pkg::word_t    mem_wdata,
    input  cache_pkg::byte_en_t mem_byte_en,
    output cache_pkg::word_t    mem_rdata,
    output logic                mem_busy
);

    // written words only, the rest follows the fill pattern
    cache_pkg::word_t stored_addr[$];
    cache_pkg::word_t stored_data[$];
    logic [1:0]       wait_cnt;
    int               n_reads;
    int               n_writes;

    function automatic cache_pkg::word_t read_word(input cache_pkg::word_t a);
        cache_pkg::word_t v;
        v = a ^ 32'hA5A5_A5A5;
        for (int i = 0; i < stored_addr.size(); i++) begin
            if (stored_addr[i] == a)
                v = stored_data[i];
        end
        return v;
    endfunction

    task automatic write_word(input cache_pkg::word_t a, input cache_pkg::word_t d,
                              input cache_pkg::byte_en_t be);
        cache_pkg::word_t merged;
        int               slot;
        merged = read_word(a);
        slot   = -1;
        for (int i = 0; i < stored_addr.size(); i++) begin
            if (stored_addr[i] == a)
                slot = i;
        end
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                merged[8*i +: 8] = d[8*i +: 8];
        end
        if (slot < 0) begin
            stored_addr.push_back(a);
            stored_data.push_back(merged);
        end else begin
            stored_data[slot] = merged;
        end
    endtask

    // two busy cycles, then one transfer cycle
    assign mem_busy = !((mem_ren || mem_wen) && (wait_cnt == 2'd2));

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt  <= '0;
            mem_rdata <= '0;
            n_reads   <= 0;
            n_writes  <= 0;
        end else if (mem_ren || mem_wen) begin
            if (wait_cnt == 2'd2) begin
                wait_cnt <= '0;
                if (mem_wen) begin
                    write_word(mem_addr, mem_wdata, mem_byte_en);
                    n_writes <= n_writes + 1;
                end else begin
                    n_reads <= n_reads + 1;
                end
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
                // read data ready for the transfer cycle
                if (wait_cnt == 2'd1)
                    mem_rdata <= read_word(mem_addr);
            end
        end else begin
            wait_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_l1_cache.sv
/*
 * testbench for the L1 data cache: clock, reset, xorshift data,
 * compare tasks and directed tests for hits, misses, uncached and flush
 */

`timescale 1ns/100ps
`default_nettype none

module tb_l1_cache;

    localparam int TIMEOUT_CYCLES = 200;

    logic                   CLK;
    logic                   nRST;
    logic                   ren;
    logic                   wen;
    cache_pkg::cache_addr_t addr;
    cache_pkg::word_t       wdata;
    cache_pkg::byte_en_t    byte_en;
    cache_pkg::word_t       rdata;
    logic                   busy;
    logic                   mem_ren;
    logic                   mem_wen;
    cache_pkg::word_t       mem_addr;
    cache_pkg::word_t       mem_wdata;
    cache_pkg::byte_en_t    mem_byte_en;
    cache_pkg::word_t       mem_rdata;
    logic                   mem_busy;
    logic                   flush;
    logic                   flush_done;
    cache_pkg::word_t       rng_state;

    l1_cache i_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .ren         (ren),
        .wen         (wen),
        .addr        (addr),
        .wdata       (wdata),
        .byte_en     (byte_en),
        .rdata       (rdata),
        .busy        (busy),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy),
        .flush       (flush),
        .flush_done  (flush_done)
    );

    mem_model i_mem (
        .CLK         (CLK),
        .nRST        (nRST),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic cache_pkg::word_t xorshift32(input cache_pkg::word_t x);
        cache_pkg::word_t s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // old word with the enabled lanes taken from the new one
    function automatic cache_pkg::word_t merge_lanes(input cache_pkg::word_t old_w,
                                                     input cache_pkg::word_t new_w,
                                                     input cache_pkg::byte_en_t lanes);
        cache_pkg::word_t w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i])
                w[8*i +: 8] = new_w[8*i +: 8];
        end
        return w;
    endfunction

    task automatic fail_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no completion of %s", what);
        fail_run();
    endtask

    task automatic compare_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                                input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_run();
        end
    endtask

    // one processor access, held until busy drops
    task automatic bus_access(input logic is_write, input cache_pkg::word_t a,
                              input cache_pkg::word_t d, input cache_pkg::byte_en_t lanes,
                              output cache_pkg::word_t rd, output int cycles);
        logic done;
        @(posedge CLK);
        ren      <= !is_write;
        wen      <= is_write;
        addr.raw <= a;
        wdata    <= d;
        byte_en  <= lanes;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge CLK);
            cycles++;
            if (!busy)
                done = 1'b1;
            else if (cycles >= TIMEOUT_CYCLES)
                report_timeout($sformatf("%s at %h", is_write ? "write" : "read", a));
        end
        rd = rdata;
        @(posedge CLK);
        ren <= 1'b0;
        wen <= 1'b0;
        // memory store and counters settle after the completing edge
        @(negedge CLK);
    endtask

    task automatic flush_and_wait(output int pulses);
        int   waited;
        logic seen;
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge CLK);
            waited++;
            if (flush_done)
                seen = 1'b1;
            else if (waited >= TIMEOUT_CYCLES)
                report_timeout("flush sweep");
        end
        pulses = 1;
        @(negedge CLK);
        if (flush_done)
            pulses++;
    endtask

    task automatic fill_and_hit_test();
        cache_pkg::word_t a;
        cache_pkg::word_t rd;
        int               cycles;
        int               reads0;
        int               writes0;
        a       = 32'h0000_1010;
        reads0  = i_mem.n_reads;
        writes0 = i_mem.n_writes;
        bus_access(1'b0, a, '0, 4'hF, rd, cycles);
        compare_word(rd, a ^ 32'hA5A5_A5A5, "fill read data");
        compare_count(i_mem.n_reads - reads0, 2, "fill memory reads");
        compare_count(i_mem.n_writes - writes0, 0, "fill memory writes");
        bus_access(1'b0, a, '0, 4'hF, rd, cycles);
        compare_word(rd, a ^ 32'hA5A5_A5A5, "hit read data");
        compare_count(cycles, 1, "hit read cycles");
        compare_count(i_mem.n_reads - reads0, 2, "memory reads after hit");
    endtask

    task automatic byte_write_hit_test();
        cache_pkg::word_t    a;
        cache_pkg::word_t    exp_w;
        cache_pkg::word_t    d;
        cache_pkg::word_t    rd;
        cache_pkg::byte_en_t lanes;
        int                  cycles;
        int                  reads0;
        int                  writes0;
        // second word of the block filled above
        a       = 32'h0000_1014;
        exp_w   = a ^ 32'hA5A5_A5A5;
        reads0  = i_mem.n_reads;
        writes0 = i_mem.n_writes;
        for (int i = 1; i < 16; i++) begin
            lanes     = i[3:0];
            rng_state = xorshift32(rng_state);
            d         = rng_state;
            bus_access(1'b1, a, d, lanes, rd, cycles);
            compare_count(cycles, 1, "write hit cycles");
            exp_w = merge_lanes(exp_w, d, lanes);
            bus_access(1'b0, a, '0, 4'hF, rd, cycles);
            compare_word(rd, exp_w, $sformatf("read after write, lanes %h", lanes));
        end
        compare_count(i_mem.n_writes - writes0, 0, "memory writes on write hits");
        compare_count(i_mem.n_reads - reads0, 0, "memory reads on write hits");
    endtask

    task automatic dirty_eviction_test();
        cache_pkg::word_t a;
        cache_pkg::word_t b;
        cache_pkg::word_t wa0;
        cache_pkg::word_t wa1;
        cache_pkg::word_t rd;
        int               cycles;
        int               reads0;
        int               writes0;
        // same index 4, tags differ in bit 16
        a         = 32'h0000_2020;
        b         = 32'h0001_2020;
        rng_state = xorshift32(rng_state);
        wa0       = rng_state;
        rng_state = xorshift32(rng_state);
        wa1       = rng_state;
        bus_access(1'b1, a, wa0, 4'hF, rd, cycles);
        bus_access(1'b1, a + 32'd4, wa1, 4'hF, rd, cycles);
        reads0  = i_mem.n_reads;
        writes0 = i_mem.n_writes;
        bus_access(1'b0, b, '0, 4'hF, rd, cycles);
        compare_word(rd, b ^ 32'hA5A5_A5A5, "conflicting read data");
        compare_count(i_mem.n_writes - writes0, 2, "victim writebacks");
        compare_count(i_mem.n_reads - reads0, 2, "conflicting fill reads");
        compare_word(i_mem.read_word(a), wa0, "memory word 0 after writeback");
        compare_word(i_mem.read_word(a + 32'd4), wa1, "memory word 1 after writeback");
        bus_access(1'b0, a, '0, 4'hF, rd, cycles);
        compare_word(rd, wa0, "re-read of evicted word");
        compare_count(i_mem.n_writes - writes0, 2, "writebacks of a clean victim");
    endtask

    task automatic pass_through_test();
        cache_pkg::word_t p;
        cache_pkg::word_t wp;
        cache_pkg::word_t wq;
        cache_pkg::word_t rd;
        int               cycles;
        int               reads0;
        int               writes0;
        p         = 32'hF000_0040;
        rng_state = xorshift32(rng_state);
        wp        = rng_state;
        reads0    = i_mem.n_reads;
        writes0   = i_mem.n_writes;
        bus_access(1'b0, p, '0, 4'hF, rd, cycles);
        compare_word(rd, p ^ 32'hA5A5_A5A5, "uncached read data");
        compare_count(i_mem.n_reads - reads0, 1, "uncached read transfers");
        bus_access(1'b1, p, wp, 4'hF, rd, cycles);
        compare_count(i_mem.n_writes - writes0, 1, "uncached write transfers");
        compare_word(i_mem.read_word(p), wp, "memory after uncached write");
        bus_access(1'b0, p, '0, 4'hF, rd, cycles);
        compare_word(rd, wp, "uncached read after write");
        bus_access(1'b0, p, '0, 4'hF, rd, cycles);
        compare_word(rd, wp, "repeat uncached read");
        compare_count(i_mem.n_reads - reads0, 3, "uncached repeat read transfers");
        // byte enables reach memory unchanged
        rng_state = xorshift32(rng_state);
        wq        = rng_state;
        bus_access(1'b1, p, wq, 4'h5, rd, cycles);
        compare_count(i_mem.n_writes - writes0, 2, "uncached partial write transfers");
        bus_access(1'b0, p, '0, 4'hF, rd, cycles);
        compare_word(rd, merge_lanes(wp, wq, 4'h5), "uncached read after partial write");
    endtask

    task automatic flush_test();
        cache_pkg::word_t addrs [3];
        cache_pkg::word_t vals  [3];
        cache_pkg::word_t rd;
        int               cycles;
        int               pulses;
        int               reads0;
        int               writes0;
        // start from an all-clean cache
        flush_and_wait(pulses);
        compare_count(pulses, 1, "flush_done pulses of first flush");
        addrs[0] = 32'h0000_3030;
        addrs[1] = 32'h0000_3038;
        addrs[2] = 32'h0000_3040;
        for (int i = 0; i < 3; i++) begin
            rng_state = xorshift32(rng_state);
            vals[i]   = rng_state;
            bus_access(1'b1, addrs[i], vals[i], 4'hF, rd, cycles);
        end
        reads0  = i_mem.n_reads;
        writes0 = i_mem.n_writes;
        flush_and_wait(pulses);
        compare_count(pulses, 1, "flush_done pulses");
        // three dirty lines, both words of each go out
        compare_count(i_mem.n_writes - writes0, 6, "flush writebacks");
        compare_count(i_mem.n_reads - reads0, 0, "memory reads during flush");
        for (int i = 0; i < 3; i++) begin
            compare_word(i_mem.read_word(addrs[i]), vals[i], "flushed dirty word");
            compare_word(i_mem.read_word(addrs[i] + 32'd4),
                         (addrs[i] + 32'd4) ^ 32'hA5A5_A5A5, "flushed clean word");
        end
        bus_access(1'b0, addrs[0], '0, 4'hF, rd, cycles);
        compare_word(rd, vals[0], "read after flush");
        compare_count(i_mem.n_reads - reads0, 2, "fresh reads after flush");
    endtask

    initial begin
        nRST      = 1'b0;
        ren       = 1'b0;
        wen       = 1'b0;
        addr      = '0;
        wdata     = '0;
        byte_en   = '0;
        flush     = 1'b0;
        rng_state = 32'h67cb_d0ca;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        compare_count(busy, 1, "busy after reset");
        compare_count(flush_done, 0, "flush_done after reset");
        fill_and_hit_test();
        byte_write_hit_test();
        dirty_eviction_test();
        pass_through_test();
        flush_test();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/cache_pkg.sv
src/store_if.sv
src/cache_decode.sv
src/cache_ctrl.sv
src/cache_store.sv
src/l1_cache.sv
tb/mem_model.sv
tb/tb_l1_cache.sv
